// File: ccip_mmio_pkg.sv
// MMIO strobes are single-cycle valids with no back-pressure; addresses are 32-bit word indices
`default_nettype none

package ccip_mmio_pkg;

  // Channel widths
  localparam int MMIO_ADDR_W = 16;
  localparam int MMIO_TID_W  = 9;
  localparam int MMIO_DATA_W = 64;

  // First word address answered by the accelerator core
  localparam int unsigned CSR_REGION_END = 'h400;

  // Request kind carried with every request slot
  typedef enum logic [1:0] {
    MMIO_NONE  = 2'b00,
    MMIO_READ  = 2'b01,
    MMIO_WRITE = 2'b10
  } t_mmio_kind;

  // Host to device request, data only meaningful for writes
  typedef struct packed {
    t_mmio_kind             kind;
    logic [MMIO_ADDR_W-1:0] address;
    logic [MMIO_TID_W-1:0]  tid;
    logic [MMIO_DATA_W-1:0] data;
  } t_mmio_req;

  // Device to host read response
  typedef struct packed {
    logic                   valid;
    logic [MMIO_TID_W-1:0]  tid;
    logic [MMIO_DATA_W-1:0] data;
  } t_mmio_rsp;

endpackage

`default_nettype wire

// File: rs_decoder_csr_pkg.sv
// Register map in 32-bit word addresses; 64-bit registers sit on even words, buffers are fixed at 4
`default_nettype none

package rs_decoder_csr_pkg;

  // Number of buffer descriptors
  localparam int HC_BUFFER_SIZE = 4;
  localparam int HC_BUF_IDX_W   = $clog2(HC_BUFFER_SIZE);

  // Cache-line address width
  localparam int HC_ADDR_W = 42;

  // Feature header words
  localparam int unsigned HC_DEVICE_HEADER = 'h0;
  localparam int unsigned HC_AFU_ID_LOW    = 'h2;
  localparam int unsigned HC_AFU_ID_HIGH   = 'h4;
  localparam int unsigned HC_DFH_RSVD0     = 'h6;
  localparam int unsigned HC_DFH_RSVD1     = 'h8;
  localparam int unsigned DFH_REGION_END   = 'h10;

  // Configuration registers
  localparam int unsigned HC_CONTROL  = 'h20;
  localparam int unsigned HC_DSM_BASE = 'h22;

  // Buffer i: address word at base + 4i, size word two above it
  localparam int unsigned HC_BUFFER_BASE = 'h30;
  localparam int unsigned HC_BUFFER_END  = HC_BUFFER_BASE + 4 * HC_BUFFER_SIZE;

  // Header and identifier constants
  localparam logic [63:0]  HC_DFH_VALUE = 64'h1000_0000_1000_0000;
  localparam logic [127:0] HC_AFU_ID    = 128'hC000C966_0D82_4272_9AEF_FE5F_8457_0612;

  // Decoder command
  typedef enum logic [1:0] {
    HC_CMD_IDLE  = 2'd0,
    HC_CMD_START = 2'd1,
    HC_CMD_STOP  = 2'd2
  } t_hc_cmd;

  // Control word, cmd in the low bits
  typedef struct packed {
    logic [23:0] rsvd;
    logic [5:0]  symbol_mode;
    t_hc_cmd     cmd;
  } t_hc_control;

  typedef logic [HC_ADDR_W-1:0] t_hc_address;

  // One buffer descriptor
  typedef struct packed {
    t_hc_address address;
    logic [31:0] size;
  } t_hc_buffer;

endpackage

`default_nettype wire

// File: dfh_read_responder.sv
// Answers reads below word 0x10 one cycle after rx_req; writes to this region are ignored
`timescale 1ns/1ns
`default_nettype none

module dfh_read_responder
  import ccip_mmio_pkg::*;
  import rs_decoder_csr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  var  t_mmio_req rx_req,
  output t_mmio_rsp      dfh_rsp
);

  logic                   dfh_read;
  logic [MMIO_DATA_W-1:0] dfh_data;

  assign dfh_read = (rx_req.kind == MMIO_READ) && (rx_req.address < DFH_REGION_END);

  // Constant word lookup
  always_comb begin
    case (rx_req.address)
      HC_DEVICE_HEADER: dfh_data = HC_DFH_VALUE;
      HC_AFU_ID_LOW:    dfh_data = HC_AFU_ID[63:0];
      HC_AFU_ID_HIGH:   dfh_data = HC_AFU_ID[127:64];
      // Reserved words read as zero
      HC_DFH_RSVD0,
      HC_DFH_RSVD1:     dfh_data = '0;
      default:          dfh_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    dfh_rsp.valid <= dfh_read;
    dfh_rsp.tid   <= rx_req.tid;
    dfh_rsp.data  <= dfh_data;
    if (reset) begin
      dfh_rsp.valid <= 1'b0;
    end
  end

  // Request register only ever carries a legal kind
  assert property (@(posedge clk) disable iff (reset)
    rx_req.kind inside {MMIO_NONE, MMIO_READ, MMIO_WRITE})
    else $error("rx_req.kind outside the request enum");

endmodule

`default_nettype wire

// File: csr_register_file.sv
// Control writes store the low 32 bits unchanged, so the host must never write an undefined cmd
`timescale 1ns/1ns
`default_nettype none

module csr_register_file
  import ccip_mmio_pkg::*;
  import rs_decoder_csr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  var  t_mmio_req rx_req,
  output t_hc_control    hc_control,
  output t_hc_address    hc_dsm_base,
  output t_hc_buffer     hc_buffer [HC_BUFFER_SIZE],
  output t_mmio_rsp      reg_rsp
);

  logic                    in_region;
  logic                    is_read;
  logic                    is_write;
  logic                    ctrl_wr;
  logic                    buf_hit;
  logic                    buf_size_sel;
  logic [MMIO_ADDR_W-1:0]  buf_offset;
  logic [HC_BUF_IDX_W-1:0] buf_idx;
  logic [MMIO_DATA_W-1:0]  rd_data;

  assign in_region = (rx_req.address >= DFH_REGION_END) && (rx_req.address < CSR_REGION_END);
  assign is_read   = (rx_req.kind == MMIO_READ) && in_region;
  assign is_write  = (rx_req.kind == MMIO_WRITE) && in_region;
  assign ctrl_wr   = is_write && (rx_req.address == HC_CONTROL);

  // Buffer window decode with only even words mapped
  assign buf_offset   = rx_req.address - MMIO_ADDR_W'(HC_BUFFER_BASE);
  assign buf_hit      = (rx_req.address >= HC_BUFFER_BASE) && (rx_req.address < HC_BUFFER_END)
                        && !buf_offset[0];
  assign buf_size_sel = buf_offset[1];
  assign buf_idx      = buf_offset[2 +: HC_BUF_IDX_W];

  always_ff @(posedge clk) begin
    if (reset) begin
      hc_control  <= '0;
      hc_dsm_base <= '0;
      for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
        hc_buffer[i] <= '0;
      end
    end else if (is_write) begin
      if (ctrl_wr) begin
        hc_control <= t_hc_control'(rx_req.data[31:0]);
      end
      // Byte addresses are kept as cache-line addresses
      if (rx_req.address == HC_DSM_BASE) begin
        hc_dsm_base <= rx_req.data[6 +: HC_ADDR_W];
      end
      if (buf_hit && buf_size_sel) begin
        hc_buffer[buf_idx].size <= rx_req.data[31:0];
      end else if (buf_hit) begin
        hc_buffer[buf_idx].address <= rx_req.data[6 +: HC_ADDR_W];
      end
    end
  end

  // Zero-extended readback with unmapped words at zero
  always_comb begin
    rd_data = '0;
    if (buf_hit) begin
      if (buf_size_sel) begin
        rd_data = MMIO_DATA_W'(hc_buffer[buf_idx].size);
      end else begin
        rd_data = MMIO_DATA_W'(hc_buffer[buf_idx].address);
      end
    end else begin
      case (rx_req.address)
        HC_CONTROL:  rd_data = MMIO_DATA_W'(hc_control);
        HC_DSM_BASE: rd_data = MMIO_DATA_W'(hc_dsm_base);
        default:     rd_data = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    reg_rsp.valid <= is_read;
    reg_rsp.tid   <= rx_req.tid;
    reg_rsp.data  <= rd_data;
    if (reset) begin
      reg_rsp.valid <= 1'b0;
    end
  end

  // A control write leaves a defined command behind
  assert property (@(posedge clk) disable iff (reset)
    ctrl_wr |=> hc_control.cmd inside {HC_CMD_IDLE, HC_CMD_START, HC_CMD_STOP})
    else $error("hc_control.cmd undefined after a control write");

endmodule

`default_nettype wire

// File: mmio_response_merge.sv
// Front-end responses win; a core response in the same cycle is lost, so one read in flight only
`timescale 1ns/1ns
`default_nettype none

module mmio_response_merge
  import ccip_mmio_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  var  t_mmio_rsp dfh_rsp,
  input  var  t_mmio_rsp reg_rsp,
  input  var  t_mmio_rsp afu_rsp,
  output t_mmio_rsp      fiu_rsp
);

  t_mmio_rsp next_rsp;

  // Priority select, the core is the fallback
  always_comb begin
    if (dfh_rsp.valid) begin
      next_rsp = dfh_rsp;
    end else if (reg_rsp.valid) begin
      next_rsp = reg_rsp;
    end else begin
      next_rsp = afu_rsp;
    end
  end

  always_ff @(posedge clk) begin
    fiu_rsp <= next_rsp;
    if (reset) begin
      fiu_rsp.valid <= 1'b0;
    end
  end

  // Address regions of the two front-end blocks are disjoint
  assert property (@(posedge clk) disable iff (reset)
    !(dfh_rsp.valid && reg_rsp.valid))
    else $error("feature header and register file responded together");

endmodule

`default_nettype wire

// File: rs_decoder_csr.sv
// Front-end reads answer in 3 cycles, writes apply in 2; requests reach the core unregistered
`timescale 1ns/1ns
`default_nettype none

module rs_decoder_csr
  import ccip_mmio_pkg::*;
  import rs_decoder_csr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  var  t_mmio_req fiu_req,
  input  var  t_mmio_rsp afu_rsp,
  output t_mmio_rsp      fiu_rsp,
  output t_mmio_req      afu_req,
  output t_hc_control    hc_control,
  output t_hc_address    hc_dsm_base,
  output t_hc_buffer     hc_buffer [HC_BUFFER_SIZE]
);

  t_mmio_req rx_req;
  t_mmio_rsp dfh_rsp;
  t_mmio_rsp reg_rsp;

  // Core sees the raw request stream
  assign afu_req = fiu_req;

  // Single request register stage
  always_ff @(posedge clk) begin
    rx_req <= fiu_req;
    if (reset) begin
      rx_req.kind <= MMIO_NONE;
    end
  end

  dfh_read_responder u_dfh (
    .clk     (clk),
    .reset   (reset),
    .rx_req  (rx_req),
    .dfh_rsp (dfh_rsp)
  );

  csr_register_file u_regs (
    .clk         (clk),
    .reset       (reset),
    .rx_req      (rx_req),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .hc_buffer   (hc_buffer),
    .reg_rsp     (reg_rsp)
  );

  mmio_response_merge u_merge (
    .clk     (clk),
    .reset   (reset),
    .dfh_rsp (dfh_rsp),
    .reg_rsp (reg_rsp),
    .afu_rsp (afu_rsp),
    .fiu_rsp (fiu_rsp)
  );

endmodule

`default_nettype wire

// File: tb_rs_decoder_csr.sv
// One request in flight at a time; write data comes from a fixed-seed LFSR, core is modelled by the TB
`timescale 1ns/1ns
`default_nettype none

module tb_rs_decoder_csr
  import ccip_mmio_pkg::*;
  import rs_decoder_csr_pkg::*;
();

  typedef struct {
    string                  name;
    t_mmio_kind             kind;
    logic [MMIO_ADDR_W-1:0] addr;
    logic [MMIO_DATA_W-1:0] data;
    bit                     core;
    logic [MMIO_DATA_W-1:0] exp;
  } row_t;

  logic        clk;
  logic        reset;
  t_mmio_req   fiu_req;
  t_mmio_rsp   afu_rsp;
  t_mmio_rsp   fiu_rsp;
  t_mmio_req   afu_req;
  t_hc_control hc_control;
  t_hc_address hc_dsm_base;
  t_hc_buffer  hc_buffer [HC_BUFFER_SIZE];

  row_t        rows [$];
  t_hc_buffer  exp_buf [HC_BUFFER_SIZE];
  logic [31:0] lfsr_state;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 0;

  rs_decoder_csr dut0 (
    .clk         (clk),
    .reset       (reset),
    .fiu_req     (fiu_req),
    .afu_rsp     (afu_rsp),
    .fiu_rsp     (fiu_rsp),
    .afu_req     (afu_req),
    .hc_control  (hc_control),
    .hc_dsm_base (hc_dsm_base),
    .hc_buffer   (hc_buffer)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [63:0] lfsr_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w = {w[62:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic add_row(input string name, input t_mmio_kind kind, input int unsigned addr,
                         input logic [63:0] data, input bit core, input logic [63:0] exp);
    row_t r;
    r.name = name;
    r.kind = kind;
    r.addr = MMIO_ADDR_W'(addr);
    r.data = data;
    r.core = core;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  // Expected values follow the register rules: low 32 bits, or byte address >> 6
  task automatic build_table();
    logic [63:0] d;
    add_row("dfh header", MMIO_READ, HC_DEVICE_HEADER, '0, 0, HC_DFH_VALUE);
    add_row("afu id low", MMIO_READ, HC_AFU_ID_LOW, '0, 0, HC_AFU_ID[63:0]);
    add_row("afu id high", MMIO_READ, HC_AFU_ID_HIGH, '0, 0, HC_AFU_ID[127:64]);
    add_row("dfh rsvd0", MMIO_READ, HC_DFH_RSVD0, '0, 0, '0);
    add_row("dfh rsvd1", MMIO_READ, HC_DFH_RSVD1, '0, 0, '0);
    // START in the cmd field
    d = lfsr_word();
    d[1:0] = 2'b01;
    add_row("control write", MMIO_WRITE, HC_CONTROL, d, 0, {32'h0, d[31:0]});
    add_row("control read", MMIO_READ, HC_CONTROL, '0, 0, {32'h0, d[31:0]});
    d = lfsr_word();
    add_row("dsm base write", MMIO_WRITE, HC_DSM_BASE, d, 0, {22'h0, d[47:6]});
    add_row("dsm base read", MMIO_READ, HC_DSM_BASE, '0, 0, {22'h0, d[47:6]});
    for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
      d = lfsr_word();
      add_row($sformatf("buffer %0d address write", i), MMIO_WRITE, HC_BUFFER_BASE + 4 * i,
              d, 0, {22'h0, d[47:6]});
      add_row($sformatf("buffer %0d address read", i), MMIO_READ, HC_BUFFER_BASE + 4 * i,
              '0, 0, {22'h0, d[47:6]});
      d = lfsr_word();
      add_row($sformatf("buffer %0d size write", i), MMIO_WRITE, HC_BUFFER_BASE + 4 * i + 2,
              d, 0, {32'h0, d[31:0]});
      add_row($sformatf("buffer %0d size read", i), MMIO_READ, HC_BUFFER_BASE + 4 * i + 2,
              '0, 0, {32'h0, d[31:0]});
    end
    add_row("unmapped word", MMIO_READ, 'h24, '0, 0, '0);
    add_row("odd buffer word", MMIO_READ, HC_BUFFER_BASE + 1, '0, 0, '0);
    add_row("core read", MMIO_READ, CSR_REGION_END, '0, 1, 64'h0bad_cafe_1234_5678);
    add_row("core read high", MMIO_READ, 'h7f0, '0, 1, lfsr_word());
  endtask

  task automatic check_rsp(input string name, input t_mmio_rsp exp, input t_mmio_rsp act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_req(input string name, input t_mmio_req exp, input t_mmio_req act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_control(input string name, input t_hc_control exp,
                               input t_hc_control act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_address(input string name, input t_hc_address exp,
                               input t_hc_address act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_buffer(input string name, input t_hc_buffer exp, input t_hc_buffer act);
    if (act !== exp) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      errors++;
      $display("FAILED %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // Outputs touched by a write, two cycles after it was driven
  task automatic check_write(input row_t r);
    int b;
    if (r.addr == HC_CONTROL) begin
      check_control(r.name, t_hc_control'(r.exp[31:0]), hc_control);
    end else if (r.addr == HC_DSM_BASE) begin
      check_address(r.name, r.exp[HC_ADDR_W-1:0], hc_dsm_base);
    end else begin
      b = (r.addr - HC_BUFFER_BASE) >> 2;
      if (r.addr[1]) begin
        exp_buf[b].size = r.exp[31:0];
      end else begin
        exp_buf[b].address = r.exp[HC_ADDR_W-1:0];
      end
      check_buffer(r.name, exp_buf[b], hc_buffer[b]);
    end
  endtask

  task automatic apply_row(input row_t r, input int idx);
    t_mmio_req req;
    t_mmio_rsp exp_rsp;
    int        lat;
    req.kind      = r.kind;
    req.address   = r.addr;
    req.tid       = MMIO_TID_W'(idx);
    req.data      = r.data;
    exp_rsp.valid = 1'b1;
    exp_rsp.tid   = MMIO_TID_W'(idx);
    exp_rsp.data  = r.exp;
    fiu_req = req;
    if (r.kind == MMIO_WRITE) begin
      @(negedge clk);
      fiu_req.kind = MMIO_NONE;
      @(negedge clk);
      check_write(r);
    end else if (r.core) begin
      @(posedge clk);
      check_req({r.name, " passthrough"}, req, afu_req);
      for (int c = 0; c < 3; c++) begin
        @(negedge clk);
        fiu_req.kind = MMIO_NONE;
        if (fiu_rsp.valid !== 1'b0) begin
          errors++;
          $display("%s: front end answered a core address", r.name);
        end
      end
      // Core answers, merge forwards it one cycle later
      afu_rsp = exp_rsp;
      @(negedge clk);
      afu_rsp = '0;
      check_rsp(r.name, exp_rsp, fiu_rsp);
    end else begin
      lat = 0;
      do begin
        @(negedge clk);
        fiu_req.kind = MMIO_NONE;
        lat++;
      end while (fiu_rsp.valid !== 1'b1 && lat < 5);
      if (fiu_rsp.valid !== 1'b1) begin
        errors++;
        $display("%s: no read response within %0d cycles", r.name, lat);
      end else begin
        check_latency(r.name, 3, lat);
        check_rsp(r.name, exp_rsp, fiu_rsp);
      end
    end
  endtask

  initial begin
    lfsr_state = 32'ha42d_f3e7;
    reset      = 1'b1;
    fiu_req    = '0;
    afu_rsp    = '0;
    for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
      exp_buf[i] = '0;
    end
    build_table();
    cycle_limit = rows.size() * 6 + 20;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    // State straight out of reset
    if (fiu_rsp.valid !== 1'b0) begin
      errors++;
      $display("fiu_rsp valid is not low after reset");
    end
    check_control("reset control", '0, hc_control);
    check_address("reset dsm base", '0, hc_dsm_base);
    for (int i = 0; i < HC_BUFFER_SIZE; i++) begin
      check_buffer($sformatf("reset buffer %0d", i), '0, hc_buffer[i]);
    end
    for (int i = 0; i < rows.size(); i++) begin
      apply_row(rows[i], i);
    end
    $display("Summary: %0d errors over %0d table rows", errors, rows.size());
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
ccip_mmio_pkg.sv
rs_decoder_csr_pkg.sv
dfh_read_responder.sv
csr_register_file.sv
mmio_response_merge.sv
rs_decoder_csr.sv
tb_rs_decoder_csr.sv

// File: Bender.yml
package:
  name: rs_decoder_csr

sources:
  - files:
      - ccip_mmio_pkg.sv
      - rs_decoder_csr_pkg.sv
      - dfh_read_responder.sv
      - csr_register_file.sv
      - mmio_response_merge.sv
      - rs_decoder_csr.sv
  - target: test
    files:
      - tb_rs_decoder_csr.sv
